/* logic/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input  logic                           clock_i,
	input  logic                           arstN_i,
	input  logic                           enable_i,
	input  xFormPkg::xFormWord_t           instruction_i,
	// table lookup
	output logic [0:xFormPkg::xoWidth-1]   xo_o,
	output logic                           single_o,
	input  logic                           fixedValid_i,
	input  logic [0:xFormPkg::unitWidth-1] fixedUnit_i,
	input  logic                           fixedZeroBase_i,
	input  logic                           floatValid_i,
	input  logic [0:xFormPkg::unitWidth-1] floatUnit_i,
	input  logic                           floatZeroBase_i,
	// decoded
	output logic                           enable_o,
	output logic                           illegal_o,
	output logic [0:xFormPkg::regWidth-1]  reg1_o,
	output logic [0:xFormPkg::regWidth-1]  reg2_o,
	output logic [0:xFormPkg::regWidth-1]  reg3_o,
	output logic [0:xFormPkg::xoWidth-1]   xOpcode_o,
	output logic                           rcBit_o,
	output logic                           reg2ValOrZero_o,
	output logic [0:xFormPkg::unitWidth-1] functionalUnitCode_o
);
	import xFormPkg::*;

	logic                 isFixed;
	logic                 isSingle;
	logic                 isFloat;
	logic                 knownPrim;
	logic                 hitValid;
	logic [0:unitWidth-1] hitUnit;
	logic                 hitZeroBase;

	////////////////////////////////////////
	// table select

	assign isFixed = instruction_i.raw.prim == primFixed;
	assign isSingle = instruction_i.raw.prim == primFloatSingle;
	assign isFloat = isSingle || (instruction_i.raw.prim == primFloat);
	assign knownPrim = isFixed || isFloat; // anything else is another decoder's

	assign xo_o = instruction_i.x.xo;
	assign single_o = isSingle;

	assign hitValid = isFixed ? fixedValid_i : floatValid_i;
	assign hitUnit = isFixed ? fixedUnit_i : floatUnit_i;
	assign hitZeroBase = isFixed ? fixedZeroBase_i : floatZeroBase_i;

	////////////////////////////////////////
	// output register

	always_ff @(posedge clock_i or negedge arstN_i) begin
		if (!arstN_i) begin
			enable_o <= 1'b0;
			illegal_o <= 1'b0;
			reg1_o <= '0;
			reg2_o <= '0;
			reg3_o <= '0;
			xOpcode_o <= '0;
			rcBit_o <= 1'b0;
			reg2ValOrZero_o <= 1'b0;
			functionalUnitCode_o <= '0;
		end else begin
			enable_o <= enable_i && knownPrim && hitValid;
			illegal_o <= enable_i && knownPrim && !hitValid;
			if (enable_i) begin // fields follow every accepted word
				reg1_o <= instruction_i.x.rt;
				reg2_o <= instruction_i.x.ra;
				reg3_o <= instruction_i.x.rb;
				xOpcode_o <= instruction_i.x.xo;
				rcBit_o <= instruction_i.x.rc;
				reg2ValOrZero_o <= hitZeroBase;
				functionalUnitCode_o <= hitUnit;
			end
		end
	end

	strobesExclusive: assert property (@(posedge clock_i) disable iff (!arstN_i)
		!(enable_o && illegal_o))
		else $error("enable and illegal strobes high together");

	// table results must never carry the unused code
	unitCodeKnown: assert property (@(posedge clock_i) disable iff (!arstN_i)
		enable_o |-> functionalUnitCode_o != 2'd3)
		else $error("unit code 3 on a legal decode");

endmodule

/* logic/fixedPointTable.sv */
`timescale 1ns/1ps

module fixedPointTable (
	input  logic [0:xFormPkg::xoWidth-1]   xo_i,
	output logic                           valid_o,
	output logic [0:xFormPkg::unitWidth-1] unit_o,
	output logic                           zeroBase_o
);
	import xFormPkg::*;

	logic indexedForm; // ra of zero reads as literal zero
	logic updateForm;  // ra is written back, always a real register
	logic fixedOp;

	always_comb begin
		indexedForm = 1'b0;
		updateForm = 1'b0;
		fixedOp = 1'b0;
		case (xo_i)
			////////////////////////////////////////
			// load/store indexed
			10'd87,  // lbzx
			10'd279, // lhzx
			10'd343,
			10'd23,  // lwzx
			10'd341,
			10'd21,  // ldx
			10'd215, // stbx
			10'd407,
			10'd151,
			10'd149, // stdx
			// byte reverse
			10'd790,
			10'd534,
			10'd918,
			10'd662,
			10'd532,
			10'd660,
			// string words
			10'd597, // lswi
			10'd533,
			10'd725, // stswi
			10'd661,
			// floating load/store, still the load/store unit
			10'd535,
			10'd599,
			10'd887,
			10'd855,
			10'd663,
			10'd727,
			10'd983,
			10'd791, // lfdpx
			10'd919: indexedForm = 1'b1;

			////////////////////////////////////////
			// load/store with update
			10'd119, // lbzux
			10'd311,
			10'd375,
			10'd55,
			10'd373,
			10'd53,  // ldux
			10'd247,
			10'd439,
			10'd183,
			10'd181,
			10'd567, // lfsux
			10'd631,
			10'd695,
			10'd759: updateForm = 1'b1;

			////////////////////////////////////////
			// fixed point unit
			10'd779, 10'd267,           // modsw moduw
			10'd777, 10'd265,           // doubleword modulo
			10'd755,                    // darn
			10'd0, 10'd32,              // cmp cmpl
			10'd192, 10'd224,
			10'd4, 10'd68,              // traps
			10'd28, 10'd444, 10'd316,
			10'd476, 10'd124, 10'd284,
			10'd60, 10'd412,            // andc orc
			10'd954, 10'd922, 10'd986,  // sign extend
			10'd26, 10'd538,
			10'd58, 10'd570,
			10'd508,
			10'd122, 10'd378, 10'd506,  // popcnt
			10'd186, 10'd154,
			10'd252,
			10'd24, 10'd536,
			10'd824, 10'd792,
			10'd27, 10'd539, 10'd794,
			10'd282, 10'd314,           // bcd
			10'd51, 10'd307, 10'd115,   // move from vsr
			10'd179, 10'd211, 10'd243,
			10'd435, 10'd403,
			10'd576,
			10'd128: fixedOp = 1'b1;    // setb

			default: fixedOp = 1'b0;
		endcase
	end

	assign valid_o = indexedForm || updateForm || fixedOp;
	assign unit_o = fixedOp ? unitFixed : unitLoadStore;
	assign zeroBase_o = indexedForm;

endmodule

/* logic/floatTable.sv */
`timescale 1ns/1ps

module floatTable (
	input  logic [0:xFormPkg::xoWidth-1]   xo_i,
	input  logic                           single_i, // primary 59
	output logic                           valid_o,
	output logic [0:xFormPkg::unitWidth-1] unit_o,
	output logic                           zeroBase_o
);
	import xFormPkg::*;

	logic doubleHit;
	logic singleHit;

	////////////////////////////////////////
	// primary 63

	always_comb begin
		case (xo_i)
			// move and sign
			10'd72,  // fmr
			10'd40,
			10'd264,
			10'd8,
			10'd136,
			10'd966, // fmrgew
			10'd838,
			// software divide / sqrt tests
			10'd128,
			10'd160,
			// rounding and conversion
			10'd12,  // frsp
			10'd814,
			10'd815,
			10'd942,
			10'd943,
			10'd14,
			10'd15,
			10'd142,
			10'd143,
			10'd846, // fcfid
			10'd974, // fcfidu
			10'd392,
			10'd424,
			10'd456,
			10'd488,
			// compares
			10'd0,
			10'd32,
			// fpscr access
			10'd583,
			10'd64,
			10'd134,
			10'd70,
			10'd38: doubleHit = 1'b1;
			default: doubleHit = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// primary 59, converts only

	always_comb begin
		case (xo_i)
			10'd846, // fcfids
			10'd974: singleHit = 1'b1;
			default: singleHit = 1'b0;
		endcase
	end

	assign valid_o = single_i ? singleHit : doubleHit;
	assign unit_o = unitFloat;
	assign zeroBase_o = 1'b0; // no address forms in this table

endmodule

/* logic/xFormDecoder.sv */
`timescale 1ns/1ps

module xFormDecoder (
	input  logic                            clock_i,
	input  logic                            arstN_i,
	input  logic                            enable_i,
	input  logic [0:xFormPkg::instrWidth-1] instruction_i,
	output logic                            enable_o,
	output logic                            illegal_o,
	output logic [0:xFormPkg::regWidth-1]   reg1_o,
	output logic [0:xFormPkg::regWidth-1]   reg2_o,
	output logic [0:xFormPkg::regWidth-1]   reg3_o,
	output logic [0:xFormPkg::xoWidth-1]    xOpcode_o,
	output logic                            rcBit_o,
	output logic                            reg2ValOrZero_o,
	output logic [0:xFormPkg::unitWidth-1]  functionalUnitCode_o
);
	import xFormPkg::*;

	logic [0:xoWidth-1]   xo;
	logic                 single;
	logic                 fixedValid;
	logic [0:unitWidth-1] fixedUnit;
	logic                 fixedZeroBase;
	logic                 floatValid;
	logic [0:unitWidth-1] floatUnit;
	logic                 floatZeroBase;

	decodeStage decodeStage_inst (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.enable_i(enable_i),
		.instruction_i(instruction_i),
		.xo_o(xo),
		.single_o(single),
		.fixedValid_i(fixedValid),
		.fixedUnit_i(fixedUnit),
		.fixedZeroBase_i(fixedZeroBase),
		.floatValid_i(floatValid),
		.floatUnit_i(floatUnit),
		.floatZeroBase_i(floatZeroBase),
		.enable_o(enable_o),
		.illegal_o(illegal_o),
		.reg1_o(reg1_o),
		.reg2_o(reg2_o),
		.reg3_o(reg3_o),
		.xOpcode_o(xOpcode_o),
		.rcBit_o(rcBit_o),
		.reg2ValOrZero_o(reg2ValOrZero_o),
		.functionalUnitCode_o(functionalUnitCode_o)
	);

	fixedPointTable fixedPointTable_inst (
		.xo_i(xo),
		.valid_o(fixedValid),
		.unit_o(fixedUnit),
		.zeroBase_o(fixedZeroBase)
	);

	floatTable floatTable_inst (
		.xo_i(xo),
		.single_i(single),
		.valid_o(floatValid),
		.unit_o(floatUnit),
		.zeroBase_o(floatZeroBase)
	);

endmodule

/* logic/xFormPkg.sv */
package xFormPkg;

	////////////////////////////////////////
	// field widths

	localparam int instrWidth = 32;
	localparam int primWidth  = 6;
	localparam int regWidth   = 5;
	localparam int xoWidth    = 10;
	localparam int unitWidth  = 2;

	////////////////////////////////////////
	// primary opcodes handled here

	localparam logic [0:primWidth-1] primFixed       = 6'd31;
	localparam logic [0:primWidth-1] primFloat       = 6'd63;
	localparam logic [0:primWidth-1] primFloatSingle = 6'd59; // single-precision arithmetic

	////////////////////////////////////////
	// functional unit codes

	localparam logic [0:unitWidth-1] unitFixed     = 2'd0;
	localparam logic [0:unitWidth-1] unitLoadStore = 2'd1;
	localparam logic [0:unitWidth-1] unitFloat     = 2'd2;
	// code 3 unused

	// bit 0 is the msb, same numbering as the ISA book
	typedef struct packed {
		logic [0:primWidth-1]            prim;
		logic [0:instrWidth-primWidth-1] payload;
	} rawView_t;

	typedef struct packed {
		logic [0:primWidth-1] prim; // bits 0..5
		logic [0:regWidth-1]  rt;   // bits 6..10
		logic [0:regWidth-1]  ra;   // bits 11..15
		logic [0:regWidth-1]  rb;   // bits 16..20
		logic [0:xoWidth-1]   xo;   // bits 21..30
		logic                 rc;   // bit 31
	} xView_t;

	// raw view picks the decoder, x view gives the fields
	typedef union packed {
		rawView_t raw;
		xView_t   x;
	} xFormWord_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f \
	--top-module xFormDecoderTb \
	-Mdir obj_dir \
	-o xFormDecoderSim

./obj_dir/xFormDecoderSim

/* src.f */
+incdir+tb
logic/xFormPkg.sv
logic/fixedPointTable.sv
logic/floatTable.sv
logic/decodeStage.sv
logic/xFormDecoder.sv
tb/xFormDecoderTb.sv

/* tb/xFormRef.svh */
`ifndef X_FORM_REF_SVH
`define X_FORM_REF_SVH

typedef struct packed {
	logic       enable;   // enable_i seen with this word
	logic       decode;
	logic       illegal;
	logic [4:0] rt;
	logic [4:0] ra;
	logic [4:0] rb;
	logic [9:0] xo;
	logic       rc;
	logic       zeroBase;
	logic [1:0] unit;
} decodeResult_t;

localparam logic [15:0] lfsrSeed = 16'd56;

////////////////////////////////////////
// opcode sets

function automatic logic isIndexedXo(input logic [9:0] xo);
	return int'(xo) inside {87, 279, 343, 23, 341, 21, 215, 407, 151, 149, 790, 534, 918,
		662, 532, 660, 597, 533, 725, 661, 535, 599, 887, 855, 663, 727, 983, 791, 919};
endfunction

function automatic logic isUpdateXo(input logic [9:0] xo);
	return int'(xo) inside {119, 311, 375, 55, 373, 53, 247, 439, 183, 181, 567, 631, 695,
		759};
endfunction

function automatic logic isFixedXo(input logic [9:0] xo);
	return int'(xo) inside {779, 267, 755, 777, 265, 0, 32, 192, 224, 4, 68, 28, 444, 316,
		476, 124, 284, 60, 412, 954, 922, 26, 538, 508, 122, 378, 186, 154, 986, 506, 58,
		570, 252, 24, 536, 824, 792, 27, 539, 794, 282, 314, 51, 307, 115, 179, 211, 243,
		435, 403, 576, 128};
endfunction

function automatic logic isDoubleXo(input logic [9:0] xo);
	return int'(xo) inside {72, 40, 264, 8, 136, 966, 838, 128, 160, 12, 814, 815, 942, 943,
		14, 15, 142, 143, 846, 974, 392, 424, 456, 488, 0, 32, 583, 64, 134, 70, 38};
endfunction

// expected decode of one word, isa bit 0 is the msb
function automatic decodeResult_t refDecode(input logic en, input logic [0:31] w);
	decodeResult_t r;
	logic [5:0]    prim;
	logic          known;
	logic          hit;
	r = '0;
	prim = w[0:5];
	r.enable = en;
	r.rt = w[6:10];
	r.ra = w[11:15];
	r.rb = w[16:20];
	r.xo = w[21:30];
	r.rc = w[31];
	hit = 1'b0;
	known = 1'b1;
	case (prim)
		6'd31: begin
			if (isIndexedXo(r.xo)) begin
				hit = 1'b1;
				r.unit = 2'd1;
				r.zeroBase = 1'b1;
			end else if (isUpdateXo(r.xo)) begin
				hit = 1'b1;
				r.unit = 2'd1;
			end else if (isFixedXo(r.xo)) begin
				hit = 1'b1;
				r.unit = 2'd0;
			end
		end
		6'd63: begin
			hit = isDoubleXo(r.xo);
			r.unit = 2'd2;
		end
		6'd59: begin
			hit = (r.xo == 10'd846) || (r.xo == 10'd974); // converts only
			r.unit = 2'd2;
		end
		default: known = 1'b0;
	endcase
	r.decode = en && known && hit;
	r.illegal = en && known && !hit;
	return r;
endfunction

// galois form, taps 16 14 13 11
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

`endif

/* tb/xFormDecoderTb.sv */
`timescale 1ns/1ps

module xFormDecoderTb;
	`include "xFormRef.svh"

	logic        clock = 1'b0;
	logic        arstN;
	logic        enableIn;
	logic [0:31] instruction;
	logic        enableOut;
	logic        illegalOut;
	logic [0:4]  reg1;
	logic [0:4]  reg2;
	logic [0:4]  reg3;
	logic [0:9]  xOpcode;
	logic        rcBit;
	logic        reg2ValOrZero;
	logic [0:1]  unitCode;

	decodeResult_t expectedQueue[$];
	string         nameQueue[$];
	logic [15:0]   lfsrState = lfsrSeed;
	logic          seenEnable = 1'b0;

	always #5 clock = ~clock;

	xFormDecoder xFormDecoder_inst (
		.clock_i(clock),
		.arstN_i(arstN),
		.enable_i(enableIn),
		.instruction_i(instruction),
		.enable_o(enableOut),
		.illegal_o(illegalOut),
		.reg1_o(reg1),
		.reg2_o(reg2),
		.reg3_o(reg3),
		.xOpcode_o(xOpcode),
		.rcBit_o(rcBit),
		.reg2ValOrZero_o(reg2ValOrZero),
		.functionalUnitCode_o(unitCode)
	);

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected 0x%0h actual 0x%0h", what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [0:31] xWord(input logic [5:0] prim, input logic [4:0] rt, ra, rb,
		input logic [9:0] xo, input logic rc);
		return {prim, rt, ra, rb, xo, rc};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	// one word per cycle, expectation queued alongside
	task automatic driveCycle(input string name, input logic en, input logic [0:31] w);
		@(posedge clock);
		#1;
		enableIn = en;
		instruction = w;
		expectedQueue.push_back(refDecode(en, w));
		nameQueue.push_back(name);
	endtask

	task automatic sweepPrimary(input string name, input logic [5:0] prim);
		for (int x = 0; x < 1024; x++) begin
			driveCycle(name, 1'b1, xWord(prim, 5'(x), 5'(x >> 5), 5'(x >> 3), 10'(x), x[0]));
		end
	endtask

	task automatic randomStream(input int count);
		logic [31:0] bits;
		logic [5:0]  prim;
		logic [0:31] w;
		logic [9:0]  commonXo [8];
		commonXo = '{10'd0, 10'd87, 10'd119, 10'd444, 10'd846, 10'd974, 10'd72, 10'd28};
		for (int k = 0; k < count; k++) begin
			takeBits(3, bits);
			case (bits[2:0])
				3'd0, 3'd1, 3'd2: prim = 6'd31;
				3'd3, 3'd4: prim = 6'd63;
				3'd5: prim = 6'd59;
				3'd6: prim = 6'd14; // someone else's primary
				default: begin
					takeBits(6, bits);
					prim = bits[5:0];
				end
			endcase
			takeBits(26, bits);
			w = {prim, bits[25:0]};
			takeBits(1, bits);
			if (bits[0]) begin
				takeBits(3, bits);
				w[21:30] = commonXo[bits[2:0]]; // bias toward table hits
			end
			driveCycle("random", 1'b1, w);
			takeBits(2, bits);
			if (bits[1:0] == 2'd0) begin
				takeBits(2, bits);
				repeat (int'(bits[1:0]) + 1) driveCycle("randomGap", 1'b0, w);
			end
		end
	endtask

	task automatic drainQueue();
		int waitCycles;
		driveCycle("drain", 1'b0, '0);
		waitCycles = 0;
		while (expectedQueue.size() > 1 && waitCycles < 20) begin
			@(negedge clock);
			waitCycles++;
		end
		if (expectedQueue.size() > 1) begin
			$display("timeout while waiting for the last results to be compared");
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	endtask

	////////////////////////////////////////
	// compare, one queued word per cycle

	always @(negedge clock) begin : compareResults
		decodeResult_t e;
		string         n;
		if (arstN && expectedQueue.size() > 1) begin
			e = expectedQueue.pop_front();
			n = nameQueue.pop_front();
			checkValue({n, " enable_o"}, 32'(e.decode), 32'(enableOut));
			checkValue({n, " illegal_o"}, 32'(e.illegal), 32'(illegalOut));
			if (enableOut) begin
				checkValue({n, " reg1_o"}, 32'(e.rt), 32'(reg1));
				checkValue({n, " reg2_o"}, 32'(e.ra), 32'(reg2));
				checkValue({n, " reg3_o"}, 32'(e.rb), 32'(reg3));
				checkValue({n, " xOpcode_o"}, 32'(e.xo), 32'(xOpcode));
				checkValue({n, " rcBit_o"}, 32'(e.rc), 32'(rcBit));
				checkValue({n, " reg2ValOrZero_o"}, 32'(e.zeroBase), 32'(reg2ValOrZero));
				checkValue({n, " functionalUnitCode_o"}, 32'(e.unit), 32'(unitCode));
			end
			if (e.enable) begin
				seenEnable = 1'b1;
			end
			if (!seenEnable) begin // fields still at reset value
				checkValue({n, " idle fields"}, 32'd0,
					32'({reg1, reg2, reg3, xOpcode, rcBit, reg2ValOrZero, unitCode}));
			end
		end
	end

	initial begin
		enableIn = 1'b0;
		instruction = '0;
		arstN = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		arstN = 1'b1;

		// legal word present but not enabled
		repeat (4) driveCycle("afterReset", 1'b0, xWord(6'd31, 5'd7, 5'd9, 5'd11, 10'd444, 1'b1));

		driveCycle("fixedFields", 1'b1, xWord(6'd31, 5'd1, 5'd2, 5'd3, 10'd0, 1'b0));
		driveCycle("fixedFields", 1'b1, xWord(6'd31, 5'd31, 5'd0, 5'd17, 10'd444, 1'b1));
		driveCycle("fixedFields", 1'b1, xWord(6'd31, 5'd21, 5'd10, 5'd31, 10'd28, 1'b1));
		driveCycle("fixedFields", 1'b1, xWord(6'd31, 5'd16, 5'd8, 5'd4, 10'd576, 1'b0));

		driveCycle("loadStore", 1'b1, xWord(6'd31, 5'd3, 5'd0, 5'd4, 10'd87, 1'b0));
		driveCycle("loadStore", 1'b1, xWord(6'd31, 5'd3, 5'd5, 5'd4, 10'd119, 1'b0));
		driveCycle("loadStore", 1'b1, xWord(6'd31, 5'd6, 5'd0, 5'd7, 10'd535, 1'b0));
		driveCycle("loadStore", 1'b1, xWord(6'd31, 5'd6, 5'd9, 5'd7, 10'd567, 1'b0));
		driveCycle("loadStore", 1'b1, xWord(6'd31, 5'd8, 5'd1, 5'd2, 10'd791, 1'b0));

		driveCycle("float", 1'b1, xWord(6'd63, 5'd1, 5'd0, 5'd2, 10'd846, 1'b1));
		driveCycle("float", 1'b1, xWord(6'd63, 5'd1, 5'd0, 5'd2, 10'd974, 1'b0));
		driveCycle("float", 1'b1, xWord(6'd63, 5'd4, 5'd0, 5'd5, 10'd72, 1'b0));
		driveCycle("float", 1'b1, xWord(6'd59, 5'd1, 5'd0, 5'd2, 10'd846, 1'b0));
		driveCycle("float", 1'b1, xWord(6'd59, 5'd1, 5'd0, 5'd2, 10'd974, 1'b1));
		driveCycle("float", 1'b1, xWord(6'd59, 5'd4, 5'd0, 5'd5, 10'd72, 1'b0));

		driveCycle("illegal", 1'b1, xWord(6'd31, 5'd1, 5'd2, 5'd3, 10'd1, 1'b0));
		driveCycle("illegal", 1'b1, xWord(6'd63, 5'd1, 5'd2, 5'd3, 10'd1, 1'b0));
		driveCycle("illegal", 1'b1, xWord(6'd14, 5'd1, 5'd2, 5'd3, 10'd0, 1'b0));
		driveCycle("illegal", 1'b1, xWord(6'd14, 5'd1, 5'd2, 5'd3, 10'd444, 1'b1));

		// every extended opcode under each primary
		sweepPrimary("sweep31", 6'd31);
		sweepPrimary("sweep63", 6'd63);
		sweepPrimary("sweep59", 6'd59);

		randomStream(400);
		drainQueue();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule
